// File: bench/aib_adaptrxdp_asserts.sv
// Concurrent checks bound onto the receive FIFO
// Lock is observed on the FIFO's wa_lock input, driven by the aligner
// All checks are off while the synchronous reset is low
`timescale 1ns/1ns
`default_nettype none

module aib_adaptrxdp_asserts (
   input logic wr_clk,
   input logic wr_rst_n,
   input logic wa_lock,       // Aligner lock
   input logic rd_valid,
   input logic fifo_empty,
   input logic fifo_full
);

   int unsigned fail_cnt = 0;   // Failed assertion count

   // Lock is sticky until reset
   a_lock_sticky: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
      !$fell(wa_lock))
   else begin
      fail_cnt++;
      $error("wa_lock fell outside reset");
   end

   // Pop only from a non-empty FIFO
   a_rd_not_empty: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
      rd_valid |-> !$past(fifo_empty))
   else begin
      fail_cnt++;
      $error("rd_valid after an empty FIFO");
   end

   a_full_empty: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
      !(fifo_full && fifo_empty))
   else begin
      fail_cnt++;
      $error("fifo_full and fifo_empty both high");
   end

endmodule

bind aib_adaptrxdp_rx_fifo aib_adaptrxdp_asserts asserts_inst (
   .wr_clk     (wr_clk),
   .wr_rst_n   (wr_rst_n),
   .wa_lock    (wa_lock),
   .rd_valid   (rd_valid),
   .fifo_empty (fifo_empty),
   .fifo_full  (fifo_full)
);

`default_nettype wire

// File: bench/tb_aib_adaptrxdp.sv
// Testbench for the AIB adapter receive slice
// Inputs change 2 ns after the rising edge, outputs are compared on the falling edge
// Reference model steps once per cycle, right after the compare
// Random markers and payloads from $urandom, fixed seed
`timescale 1ns/1ns
`default_nettype none

module tb_aib_adaptrxdp;

   import aib_rxdp_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int FIFO_DEPTH = DEF_FIFO_DEPTH;
   localparam int RST_CYC    = 16;
   localparam logic [5:0] LOCK_PAT = 6'b010101;   // Stage 0 newest holds 1, then 0,1,0,1,0

   // Cycles per test, reset included
   localparam int T1_CYC    = RST_CYC + 1 + 40 + 8;
   localparam int T2_CYC    = RST_CYC + 1 + 14;
   localparam int T3_CYC    = RST_CYC + 1 + 6 + 60 + 10;
   localparam int T4_CYC    = RST_CYC + 1 + 6 + (FIFO_DEPTH + 4) + (FIFO_DEPTH + 2);
   localparam int T5_CYC    = RST_CYC + 1 + 6 + 60 + 300;
   localparam int TOTAL_CYC = T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC;
   localparam int WD_TIME   = (TOTAL_CYC + 50) * CLK_PERIOD;   // 50 cycles of margin

   logic      wr_clk = 1'b0;
   logic      wr_rst_n;
   logic      r_wa_en;
   rx_word_t  aib_hssi_rx_data_in;
   logic      rd_en;
   logic      wa_lock;
   err_cnt_t  err_cnt;
   payload_t  rd_data;
   logic      rd_valid;
   logic      fifo_empty;
   logic      fifo_full;
   logic      fifo_ovf;
   testbus_t  word_align_testbus;

   int unsigned pass_total = 0;
   int unsigned fail_total = 0;

   //----------------------------------------
   // Reference model state
   //----------------------------------------
   logic [5:0] m_hist;        // Marker history, bit 0 newest
   logic       m_lock_lt;     // Latched lock
   logic       m_prev;        // Marker of the previous edge
   logic       m_seen;        // A locked edge has passed
   err_cnt_t   m_err;
   payload_t   m_q[$];        // Expected FIFO contents
   logic       m_rd_valid;
   payload_t   m_rd_data;
   logic       m_ovf;

   logic       next_mark;                   // Marker that keeps alternation
   logic [5:0] gen_hist;                    // Markers sent in test 1
   payload_t   first_words [FIFO_DEPTH];    // Words expected back in test 4

   aib_adaptrxdp_top #(
      .FIFO_DEPTH          (FIFO_DEPTH)
   ) aib_adaptrxdp_top_inst (
      .wr_clk              (wr_clk),
      .wr_rst_n            (wr_rst_n),
      .r_wa_en             (r_wa_en),
      .aib_hssi_rx_data_in (aib_hssi_rx_data_in),
      .rd_en               (rd_en),
      .wa_lock             (wa_lock),
      .err_cnt             (err_cnt),
      .rd_data             (rd_data),
      .rd_valid            (rd_valid),
      .fifo_empty          (fifo_empty),
      .fifo_full           (fifo_full),
      .fifo_ovf            (fifo_ovf),
      .word_align_testbus  (word_align_testbus)
   );

   always #(CLK_PERIOD / 2) wr_clk = ~wr_clk;

   //----------------------------------------
   // Reference model
   //----------------------------------------
   // Lock as seen between edges, bypass wins
   function automatic logic ref_lock();
      return (m_hist == LOCK_PAT) || !r_wa_en || m_lock_lt;
   endfunction

   // Advance the model across the next rising edge
   function automatic void ref_step();
      logic lock;
      logic mark;
      logic was_full;
      logic was_empty;
      lock      = ref_lock();
      mark      = aib_hssi_rx_data_in[MARKER_BIT];
      was_full  = (m_q.size() == FIFO_DEPTH);
      was_empty = (m_q.size() == 0);
      if (!wr_rst_n) begin
         m_hist     = '0;
         m_lock_lt  = 1'b0;
         m_prev     = 1'b0;
         m_seen     = 1'b0;
         m_err      = '0;
         m_rd_valid = 1'b0;
         m_ovf      = 1'b0;
         m_q.delete();
      end else begin
         // Monitor skips the first locked edge
         if (lock && m_seen && (mark == m_prev) && (m_err != 8'd255)) begin
            m_err = m_err + 8'd1;
         end
         if (lock) begin
            m_seen = 1'b1;
         end
         m_prev = mark;
         // FIFO flags taken before the edge
         m_rd_valid = rd_en && !was_empty;
         if (m_rd_valid) begin
            m_rd_data = m_q.pop_front();
         end
         if (lock && was_full) begin
            m_ovf = 1'b1;                           // Word dropped
         end else if (lock) begin
            m_q.push_back(aib_hssi_rx_data_in[MARKER_BIT-1:0]);
         end
         m_lock_lt = lock;
         m_hist    = {m_hist[4:0], mark};
      end
   endfunction

   task automatic compare_val(input string name, input logic [63:0] exp_v,
                              input logic [63:0] act_v);
      if (act_v !== exp_v) begin
         $display("ERR t=%0t %s expected %h actual %h", $time, name, exp_v, act_v);
         fail_total++;
      end else begin
         pass_total++;
      end
   endtask

   // Compare, then step the model
   always @(negedge wr_clk) begin
      if (wr_rst_n) begin
         compare_val("wa_lock", ref_lock(), wa_lock);
         compare_val("word_align_testbus",
                     {13'd0, ref_lock(), m_hist[0], m_hist[1], m_hist[2],
                      m_hist[3], m_hist[4], m_hist[5]},
                     word_align_testbus);
         compare_val("err_cnt", m_err, err_cnt);
         compare_val("rd_valid", m_rd_valid, rd_valid);
         if (m_rd_valid) begin
            compare_val("rd_data", m_rd_data, rd_data);
         end
         compare_val("fifo_empty", m_q.size() == 0, fifo_empty);
         compare_val("fifo_full", m_q.size() == FIFO_DEPTH, fifo_full);
         compare_val("fifo_ovf", m_ovf, fifo_ovf);
      end
      ref_step();
   end

   //----------------------------------------
   // Stimulus helpers
   //----------------------------------------
   function automatic payload_t rand_payload();
      logic [63:0] r;
      r = {$urandom, $urandom};
      return r[MARKER_BIT-1:0];
   endfunction

   // Hold one word for one edge, return 2 ns after it
   task automatic drive_word(input logic mark, input payload_t p, input logic rd);
      aib_hssi_rx_data_in = {mark, p};
      rd_en               = rd;
      @(posedge wr_clk);
      #2;
   endtask

   task automatic apply_reset(input logic wa_en);
      @(posedge wr_clk);
      #2;
      wr_rst_n            = 1'b0;
      r_wa_en             = wa_en;         // Changes only under reset
      aib_hssi_rx_data_in = '0;
      rd_en               = 1'b0;
      repeat (RST_CYC) @(posedge wr_clk);
      #2;
      wr_rst_n = 1'b1;
   endtask

   // Oldest first 0,1,0,1,0,1 completes the pattern
   task automatic lock_up();
      logic mark;
      mark = 1'b0;
      repeat (6) begin
         drive_word(mark, rand_payload(), 1'b0);
         mark = ~mark;
      end
      next_mark = mark;
   endtask

   task automatic report_test(input string name, input int unsigned base);
      if (fail_total == base) begin
         $display("Test %s: passed", name);
      end else begin
         $display("Test %s: failed with %0d errors", name, fail_total - base);
      end
   endtask

   //----------------------------------------
   // Watchdog
   //----------------------------------------
   initial begin
      #(WD_TIME);
      $display("Timeout: run did not finish within %0d ns", WD_TIME);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   //----------------------------------------
   // Test sequence
   //----------------------------------------
   initial begin
      int unsigned base;
      int unsigned assert_fails;
      int          n;
      logic        mark;
      payload_t    p;
      wr_rst_n            = 1'b0;
      r_wa_en             = 1'b1;
      aib_hssi_rx_data_in = '0;
      rd_en               = 1'b0;
      void'($urandom(88711));

      // 1: random markers, no six-sample run, then alternation
      base = fail_total;
      apply_reset(1'b1);
      gen_hist = '0;
      repeat (40) begin
         mark = 1'($urandom % 2);
         if ({gen_hist[4:0], mark} == LOCK_PAT) begin
            mark = 1'b0;                             // Breaks the run
         end
         gen_hist = {gen_hist[4:0], mark};
         drive_word(mark, rand_payload(), 1'b0);
      end
      compare_val("wa_lock", 0, wa_lock);
      mark = ~gen_hist[0];
      repeat (8) begin
         drive_word(mark, rand_payload(), 1'b0);
         mark = ~mark;
      end
      compare_val("wa_lock", 1, wa_lock);
      report_test("1 lock acquisition", base);

      // 2: bypass, lock and storage from the first cycle
      base = fail_total;
      apply_reset(1'b0);
      compare_val("wa_lock", 1, wa_lock);
      repeat (6) drive_word(1'($urandom % 2), rand_payload(), 1'b0);
      compare_val("fifo_empty", 0, fifo_empty);
      repeat (8) drive_word(1'($urandom % 2), rand_payload(), 1'b1);
      report_test("2 bypass", base);

      // 3: payloads with random reads
      base = fail_total;
      apply_reset(1'b1);
      lock_up();
      repeat (60) begin
         drive_word(next_mark, rand_payload(), ($urandom % 8) != 0);
         next_mark = ~next_mark;
      end
      repeat (10) begin
         drive_word(next_mark, rand_payload(), 1'b1);
         next_mark = ~next_mark;
      end
      report_test("3 payload path", base);

      // 4: overflow with reads held off
      base = fail_total;
      apply_reset(1'b1);
      lock_up();
      for (int i = 0; i < FIFO_DEPTH + 4; i++) begin
         p = rand_payload();
         if (i < FIFO_DEPTH) begin
            first_words[i] = p;
         end
         drive_word(next_mark, p, 1'b0);
         next_mark = ~next_mark;
      end
      compare_val("fifo_full", 1, fifo_full);
      compare_val("fifo_ovf", 1, fifo_ovf);
      n = 0;
      for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
         drive_word(next_mark, rand_payload(), i < FIFO_DEPTH);
         next_mark = ~next_mark;
         if (rd_valid && (n < FIFO_DEPTH)) begin
            compare_val("rd_data", first_words[n], rd_data);
            n++;
         end
      end
      compare_val("read_count", FIFO_DEPTH, n);
      compare_val("fifo_ovf", 1, fifo_ovf);
      report_test("4 overflow", base);

      // 5: repeated markers, then a stuck marker
      base = fail_total;
      apply_reset(1'b1);
      lock_up();
      repeat (60) begin
         mark = next_mark;
         if (($urandom % 4) == 0) begin
            mark = ~next_mark;                       // Same as the last one
         end
         drive_word(mark, rand_payload(), 1'b1);
         next_mark = ~mark;
      end
      repeat (300) drive_word(1'b1, rand_payload(), 1'b1);
      compare_val("err_cnt", 255, err_cnt);
      report_test("5 marker errors", base);

      assert_fails = aib_adaptrxdp_top_inst.aib_adaptrxdp_rx_fifo_inst.asserts_inst.fail_cnt;
      $display("Summary: %0d checks passed, %0d errors, %0d assertion failures",
               pass_total, fail_total, assert_fails);
      if ((fail_total == 0) && (assert_fails == 0)) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: logic/aib_adaptrxdp_marker_mon.sv
// Marker monitor for the receive datapath
// Counts words whose marker repeats the previous one, only after lock
// The first locked edge is never counted, as it has no locked history
// Count saturates at 255 and clears only on reset
// Reset is synchronous, active low
`timescale 1ns/1ns
`default_nettype none

module aib_adaptrxdp_marker_mon (
   input  logic                    wr_clk,               // Receive word clock
   input  logic                    wr_rst_n,             // Sync reset, active low
   input  logic                    wa_lock,              // From aligner
   input  aib_rxdp_pkg::rx_word_t  aib_hssi_rx_data_in,  // Raw word from transceiver
   output aib_rxdp_pkg::err_cnt_t  err_cnt               // Marker error count
);

   import aib_rxdp_pkg::*;

   localparam err_cnt_t CNT_MAX = '1;   // Saturation value

   logic prev_mark;     // Marker seen on the previous edge
   logic locked_seen;   // At least one locked edge has passed
   logic cur_mark;      // Marker of the incoming word
   logic mark_rep;      // Marker failed to alternate

   assign cur_mark = aib_hssi_rx_data_in[MARKER_BIT];

   // Repeat only counts once a locked history exists
   assign mark_rep = wa_lock && locked_seen && (cur_mark == prev_mark);

   //----------------------------------------
   // Marker history and lock tracking
   //----------------------------------------
   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         prev_mark   <= 1'b0;
         locked_seen <= 1'b0;
      end else begin
         prev_mark <= cur_mark;           // Every edge, locked or not
         if (wa_lock) begin
            locked_seen <= 1'b1;          // Arms the compare for next edge
         end
      end
   end

   //----------------------------------------
   // Saturating error counter
   //----------------------------------------
   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         err_cnt <= '0;
      end else if (mark_rep && (err_cnt != CNT_MAX)) begin
         err_cnt <= err_cnt + 8'd1;       // Hold at max
      end
   end

endmodule

`default_nettype wire

// File: logic/aib_adaptrxdp_rx_fifo.sv
// Receive FIFO for the datapath slice, single clock on wr_clk
// Writes one payload per locked cycle with the marker stripped
// Write side cannot stall, so a write into a full FIFO is dropped
// and the sticky overflow flag is set
// Read data and valid are registered, one cycle after rd_en
// FIFO_DEPTH must be a power of two, at least 4
// Reset is synchronous, active low
`timescale 1ns/1ns
`default_nettype none

module aib_adaptrxdp_rx_fifo #(
   parameter int FIFO_DEPTH = 8                          // Entries, power of two
) (
   input  logic                    wr_clk,               // Receive word clock
   input  logic                    wr_rst_n,             // Sync reset, active low
   input  logic                    wa_lock,              // Write enable from aligner
   input  aib_rxdp_pkg::rx_word_t  aib_hssi_rx_data_in,  // Raw word from transceiver
   input  logic                    rd_en,                // Pop request
   output aib_rxdp_pkg::payload_t  rd_data,              // Popped payload
   output logic                    rd_valid,             // rd_data valid this cycle
   output logic                    fifo_empty,           // No entries
   output logic                    fifo_full,            // All entries used
   output logic                    fifo_ovf              // Sticky, write was dropped
);

   import aib_rxdp_pkg::*;

   localparam int AW = $clog2(FIFO_DEPTH);  // Address width

   //----------------------------------------
   // Depth check at elaboration
   //----------------------------------------
   if ((FIFO_DEPTH < 4) || ((FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0)) begin : g_depth_chk
      $error("FIFO_DEPTH must be a power of two, at least 4");
   end

   payload_t     mem [FIFO_DEPTH];   // Storage
   logic [AW:0]  wr_ptr;             // Extra wrap bit
   logic [AW:0]  rd_ptr;             // Extra wrap bit
   logic         wr_do;              // Write accepted
   logic         rd_do;              // Read accepted
   payload_t     wr_payload;         // Word minus marker

   assign wr_payload = aib_hssi_rx_data_in[MARKER_BIT-1:0];

   //----------------------------------------
   // Flags
   //----------------------------------------
   // Same address, wrap bits decide full or empty
   assign fifo_empty = (wr_ptr == rd_ptr);
   assign fifo_full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                       (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

   assign wr_do = wa_lock && !fifo_full;   // Lock gates every write
   assign rd_do = rd_en && !fifo_empty;    // Read while empty ignored

   //----------------------------------------
   // Write side
   //----------------------------------------
   always_ff @(posedge wr_clk) begin
      if (wr_do) begin
         mem[wr_ptr[AW-1:0]] <= wr_payload;
      end
   end

   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         wr_ptr   <= '0;
         fifo_ovf <= 1'b0;
      end else begin
         if (wr_do) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (wa_lock && fifo_full) begin
            fifo_ovf <= 1'b1;             // Word lost, flag stays
         end
      end
   end

   //----------------------------------------
   // Read side
   //----------------------------------------
   // Payload register, loads only on a pop
   always_ff @(posedge wr_clk) begin
      if (rd_do) begin
         rd_data <= mem[rd_ptr[AW-1:0]];  // Oldest entry
      end
   end

   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         rd_ptr   <= '0;
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= rd_do;               // One-cycle strobe
         if (rd_do) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/aib_adaptrxdp_top.sv
// Top level of the AIB adapter receive slice
// Aligner, marker monitor and receive FIFO, all on wr_clk
// No clock crossing, bit slip or deskew in this slice
// r_wa_en is a plain level input, no register interface
// Reset is synchronous, active low
`timescale 1ns/1ns
`default_nettype none

module aib_adaptrxdp_top #(
   parameter int FIFO_DEPTH = aib_rxdp_pkg::DEF_FIFO_DEPTH   // Passed to the FIFO
) (
   input  logic                    wr_clk,               // Receive word clock
   input  logic                    wr_rst_n,             // Sync reset, active low
   input  logic                    r_wa_en,              // Word-align enable
   input  aib_rxdp_pkg::rx_word_t  aib_hssi_rx_data_in,  // One word per cycle
   input  logic                    rd_en,                // FIFO pop request
   output logic                    wa_lock,              // Alignment lock status
   output aib_rxdp_pkg::err_cnt_t  err_cnt,              // Marker error count
   output aib_rxdp_pkg::payload_t  rd_data,              // FIFO read data
   output logic                    rd_valid,             // Read data strobe
   output logic                    fifo_empty,           // FIFO status
   output logic                    fifo_full,            // FIFO status
   output logic                    fifo_ovf,             // Sticky overflow
   output aib_rxdp_pkg::testbus_t  word_align_testbus    // Aligner debug
);

   //----------------------------------------
   // Word aligner
   //----------------------------------------
   aib_adaptrxdp_word_align aib_adaptrxdp_word_align_inst (
      .wr_clk              (wr_clk),
      .wr_rst_n            (wr_rst_n),
      .r_wa_en             (r_wa_en),
      .aib_hssi_rx_data_in (aib_hssi_rx_data_in),
      .wa_lock             (wa_lock),             // Fans out to monitor and FIFO
      .word_align_testbus  (word_align_testbus)
   );

   //----------------------------------------
   // Marker monitor
   //----------------------------------------
   // Checks framing health after lock
   aib_adaptrxdp_marker_mon aib_adaptrxdp_marker_mon_inst (
      .wr_clk              (wr_clk),
      .wr_rst_n            (wr_rst_n),
      .wa_lock             (wa_lock),
      .aib_hssi_rx_data_in (aib_hssi_rx_data_in),
      .err_cnt             (err_cnt)
   );

   //----------------------------------------
   // Receive FIFO
   //----------------------------------------
   aib_adaptrxdp_rx_fifo #(
      .FIFO_DEPTH          (FIFO_DEPTH)
   ) aib_adaptrxdp_rx_fifo_inst (
      .wr_clk              (wr_clk),
      .wr_rst_n            (wr_rst_n),
      .wa_lock             (wa_lock),             // Lock gates writes
      .aib_hssi_rx_data_in (aib_hssi_rx_data_in),
      .rd_en               (rd_en),
      .rd_data             (rd_data),
      .rd_valid            (rd_valid),
      .fifo_empty          (fifo_empty),
      .fifo_full           (fifo_full),
      .fifo_ovf            (fifo_ovf)
   );

endmodule

`default_nettype wire

// File: logic/aib_adaptrxdp_word_align.sv
// Word aligner for the receive datapath
// Watches the marker bit and locks after six alternating samples
// Lock is sticky until reset, no relock or slip support
// With r_wa_en low the lock output is forced high combinationally
// Reset is synchronous, active low
`timescale 1ns/1ns
`default_nettype none

module aib_adaptrxdp_word_align (
   input  logic                    wr_clk,               // Receive word clock
   input  logic                    wr_rst_n,             // Sync reset, active low
   input  logic                    r_wa_en,              // Word-align enable
   input  aib_rxdp_pkg::rx_word_t  aib_hssi_rx_data_in,  // Raw word from transceiver
   output logic                    wa_lock,              // To monitor and FIFO
   output aib_rxdp_pkg::testbus_t  word_align_testbus    // Debug visibility
);

   import aib_rxdp_pkg::*;

   // hist[0] is the newest marker sample
   localparam logic [5:0] ALT_PATTERN = 6'b010101;  // Newest 1, then 0, 1, 0, 1, 0

   logic [5:0] hist;          // Marker history, six stages
   logic       detect;        // Pattern seen or bypass
   logic       lock_lt;       // Latched lock

   //----------------------------------------
   // Marker history
   //----------------------------------------
   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         hist <= '0;
      end else begin
         hist <= {hist[4:0], aib_hssi_rx_data_in[MARKER_BIT]};  // Shift in newest
      end
   end

   // Alternation check on all six stages
   assign detect = (hist == ALT_PATTERN) || !r_wa_en;

   //----------------------------------------
   // Sticky lock
   //----------------------------------------
   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         lock_lt <= 1'b0;
      end else begin
         lock_lt <= detect || lock_lt;    // Never falls once set
      end
   end

   // Same-cycle lock on pattern completion
   assign wa_lock = detect || lock_lt;

   //----------------------------------------
   // Testbus
   //----------------------------------------
   // Zeros, lock, then history newest first
   assign word_align_testbus = {13'd0,
                                wa_lock,
                                hist[0],
                                hist[1],
                                hist[2],
                                hist[3],
                                hist[4],
                                hist[5]};

endmodule

`default_nettype wire

// File: logic/aib_rxdp_pkg.sv
// Shared types and constants for the AIB adapter receive slice
// Word width is fixed at 40 bits, and the marker sits in the top bit
// The payload is the word with the marker stripped, 39 bits
// FIFO depth must be a power of two and at least 4
`default_nettype none

package aib_rxdp_pkg;

   //----------------------------------------
   // Word format
   //----------------------------------------
   localparam int RX_DWIDTH  = 40;              // Transceiver word width
   localparam int MARKER_BIT = RX_DWIDTH - 1;   // Alternating framing marker, bit 39

   // One received word, marker included
   typedef logic [RX_DWIDTH-1:0] rx_word_t;

   // Word with marker removed
   typedef logic [RX_DWIDTH-2:0] payload_t;

   //----------------------------------------
   // Status and debug
   //----------------------------------------
   typedef logic [7:0]  err_cnt_t;              // Marker errors, saturates at 255
   typedef logic [19:0] testbus_t;              // Aligner debug bus

   //----------------------------------------
   // Buffer sizing
   //----------------------------------------
   localparam int DEF_FIFO_DEPTH = 8;           // Default entries, power of two

endpackage

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the receive slice testbench with Verilator
# Exit status is 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_aib_adaptrxdp -f src.f \
   && ./obj_dir/Vtb_aib_adaptrxdp 2>&1 | tee "$LOG" \
   && grep -q "^TEST RESULT: PASS$" "$LOG" \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

// File: src.f
logic/aib_rxdp_pkg.sv
logic/aib_adaptrxdp_word_align.sv
logic/aib_adaptrxdp_marker_mon.sv
logic/aib_adaptrxdp_rx_fifo.sv
logic/aib_adaptrxdp_top.sv
bench/aib_adaptrxdp_asserts.sv
bench/tb_aib_adaptrxdp.sv
